/* test/exec_tests.txt */
// columns: op set_flags operand_a operand_b expected_result expected_flags (all hex)
// flags are NZCV (N=8 Z=4 C=2 V=1), the flag register after the line, starting from 0
// add and subtract with carry, borrow and overflow
03 1 00000001 00000002 00000003 0
03 1 7FFFFFFF 00000001 80000000 9
03 1 FFFFFFFF 00000001 00000000 6
03 1 80000000 80000000 00000000 7
03 1 80000000 FFFFFFFF 7FFFFFFF 3
04 1 80000000 00000001 7FFFFFFF 3
04 1 00000005 00000005 00000000 6
04 1 00000003 00000005 FFFFFFFE 8
04 1 7FFFFFFF FFFFFFFF 80000000 9
03 0 12345678 11111111 23456789 9
04 1 00000000 00000000 00000000 6
03 1 40000000 40000000 80000000 9
// logic and multiply keep C and V
05 1 F0F0F0F0 0FF00FF0 00F000F0 1
06 1 80000000 00000001 80000001 9
07 1 A5A5A5A5 A5A5A5A5 00000000 5
03 1 FFFFFFFF 00000002 00000001 2
0a 1 00000000 00000000 FFFFFFFF A
0b 1 FFFF0000 F0F0F0F0 0F0F0000 2
09 1 00010000 00010000 00000000 6
09 1 12345678 00000003 369D0368 2
09 1 FFFFFFFF 00000002 FFFFFFFE A
09 0 00000007 00000006 0000002A A
06 0 00000000 00000000 00000000 A
// shifts and rotate
04 1 80000000 00000001 7FFFFFFF 3
00 1 00000001 00000004 00000010 3
00 1 00000001 0000011F 80000000 B
00 1 FFFFFFFF 00000020 00000000 7
00 1 12345678 00000100 12345678 3
01 1 80000000 0000001F 00000001 3
01 1 F0000000 000000FF 00000000 7
01 1 F0000000 00000004 0F000000 3
02 1 80000000 00000004 F8000000 B
02 1 80000000 00000040 FFFFFFFF B
02 1 40000000 000000FF 00000000 7
02 1 8000000F 00000201 C0000007 B
08 1 12345678 00000004 81234567 B
08 1 12345678 00000024 81234567 B
08 1 00000001 00000001 80000000 B
08 1 12345678 00000020 12345678 3
08 1 80000001 0000001F 00000003 3
00 0 00000003 00000002 0000000C 3
// extensions and byte reversals
0c 1 00008001 00000000 FFFF8001 B
0c 1 12347FFF 00000000 00007FFF 3
0d 1 00000080 00000000 FFFFFF80 B
0d 1 1234567F 00000000 0000007F 3
0e 1 FFFF8001 00000000 00008001 3
0f 1 123456F0 00000000 000000F0 3
0f 1 12345600 00000000 00000000 7
10 1 12345678 00000000 78563412 3
10 1 000000F1 00000000 F1000000 B
11 1 12345678 00000000 34127856 3
11 1 00FF0080 00000000 FF008000 B
12 1 12345678 00000000 00007856 3
12 1 00000080 00000000 FFFF8000 B
12 1 0000FF00 00000000 000000FF 3
// requests without set_flags leave the flag register alone
03 1 7FFFFFFF 00000001 80000000 9
04 0 00000005 00000005 00000000 9
03 0 FFFFFFFF 00000001 00000000 9
0a 0 00000000 00000000 FFFFFFFF 9
02 0 80000000 00000020 FFFFFFFF 9
10 0 00000000 00000000 00000000 9
05 1 FFFFFFFF 00000000 00000000 5
0f 0 000000AB 00000000 000000AB 5
04 1 00000001 00000002 FFFFFFFF 8
09 0 00000000 12345678 00000000 8
03 1 00000000 00000000 00000000 4
06 1 00000000 00000000 00000000 4
04 1 FFFFFFFF FFFFFFFF 00000000 6
07 0 12345678 87654321 95511559 6
0b 1 12345678 12345678 00000000 6

/* compile.f */
source/exec_pkg.sv
source/exec_input_buffer.sv
source/alu.sv
source/exec_output_stage.sv
source/exec_unit.sv
test/exec_unit_assertions.sv
test/exec_unit_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# builds the execute unit testbench with Verilator and runs it from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timing --top-module exec_unit_tb \
    -f compile.f -o exec_unit_sim \
    && ./obj_dir/exec_unit_sim \
    && echo "simulation run ended without errors" \
    || { echo "simulation run ended with errors"; exit 1; }

/* test/exec_unit_tb.sv */
`timescale 1ns/100ps

module exec_unit_tb;
    import exec_pkg::*;

    localparam int CLK_PERIOD   = 100;
    localparam int RESET_CYCLES = 10;
    localparam int MAX_VECTORS  = 256;
    // op, set_flags, operand_a, operand_b, result, flags
    localparam int FIELDS       = 6;

    logic          clk_i;
    logic          reset_i     = 1'b1;
    logic          req_valid_i = 1'b0;
    exec_req_t     req_i       = '0;
    logic          req_ready_o;
    logic          rsp_valid_o;
    exec_rsp_t     rsp_o;
    logic          rsp_ready_i = 1'b0;
    status_flags_t flags_o;

    logic [31:0] test_mem [0:MAX_VECTORS*FIELDS-1];
    int          num_vectors = 0;
    int          issue_idx   = 0;
    int          check_idx   = 0;
    int          seed        = 85;
    logic        loaded      = 1'b0;

    exec_unit u_exec_unit (
        .clk_i       (clk_i),
        .reset_i     (reset_i),
        .req_valid_i (req_valid_i),
        .req_i       (req_i),
        .req_ready_o (req_ready_o),
        .rsp_valid_o (rsp_valid_o),
        .rsp_o       (rsp_o),
        .rsp_ready_i (rsp_ready_i),
        .flags_o     (flags_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #(CLK_PERIOD/2) clk_i = ~clk_i;
    end

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        if (got !== expected) begin
            $display("MISMATCH %s: got 0x%h expected 0x%h at vector %0d",
                     name, got, expected, check_idx);
            $display("Result: FAILED");
            $fatal(1, "%s does not match the expected value", name);
        end
    endtask

    // the op slot of an unused entry is never a legal op code, which marks the end
    task automatic load_vectors();
        int i;
        for (i = 0; i < MAX_VECTORS*FIELDS; i++) begin
            test_mem[i] = 32'hEE00_0000 | i;
        end
        $readmemh("test/exec_tests.txt", test_mem);
        while (num_vectors < MAX_VECTORS && test_mem[num_vectors*FIELDS] <= 32'd18) begin
            num_vectors++;
        end
        if (num_vectors == 0) begin
            $display("no test vectors could be read from test/exec_tests.txt");
            $display("Result: FAILED");
            $fatal(1, "empty test vector file");
        end
        $display("loaded %0d test vectors", num_vectors);
    endtask

    function automatic exec_req_t vector_request(input int idx);
        exec_req_t req;
        req.op        = alu_op_e'(test_mem[idx*FIELDS][4:0]);
        req.set_flags = test_mem[idx*FIELDS+1][0];
        req.operand_a = test_mem[idx*FIELDS+2];
        req.operand_b = test_mem[idx*FIELDS+3];
        return req;
    endfunction

    // while a response sits in the output register the flag register holds
    // exactly the flags that belong to it
    task automatic check_response();
        if (check_idx >= num_vectors) begin
            $display("a response arrived after all %0d vectors were checked", num_vectors);
            $display("Result: FAILED");
            $fatal(1, "extra response");
        end
        check_value("rsp_o.result", rsp_o.result, test_mem[check_idx*FIELDS+4]);
        check_value("rsp_o.flags", 32'(rsp_o.flags), test_mem[check_idx*FIELDS+5]);
        check_value("flags_o", 32'(flags_o), test_mem[check_idx*FIELDS+5]);
        check_idx++;
    endtask

    // producer and consumer share one process so the random sequence is fixed
    always @(posedge clk_i) begin
        if (!reset_i && loaded) begin
            if (rsp_valid_o && rsp_ready_i) begin
                check_response();
            end

            if (req_valid_i && req_ready_o) begin
                issue_idx = issue_idx + 1;
            end
            // a pending request stays on the bus until it is taken
            if (!req_valid_i || req_ready_o) begin
                if (issue_idx < num_vectors && (($random(seed) & 3) != 0)) begin
                    req_valid_i <= 1'b1;
                    req_i       <= vector_request(issue_idx);
                end else begin
                    req_valid_i <= 1'b0;
                end
            end

            rsp_ready_i <= (($random(seed) & 3) != 0);
        end
    end

    initial begin
        load_vectors();
        loaded = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk_i);
        reset_i <= 1'b0;
        wait (check_idx == num_vectors);
        $display("all %0d responses matched", num_vectors);
        $display("Result: PASSED");
        $finish;
    end

    initial begin
        wait (loaded);
        repeat (num_vectors * 20 + 100) @(posedge clk_i);
        $display("responses stopped arriving, %0d of %0d vectors checked",
                 check_idx, num_vectors);
        $display("Result: FAILED");
        $fatal(1, "watchdog expired");
    end

endmodule

/* test/exec_unit_assertions.sv */
`timescale 1ns/100ps

module exec_unit_assertions (
    input logic                clk_i,
    input logic                reset_i,
    input logic                req_ready_o,
    input logic                rsp_valid_o,
    input logic                rsp_ready_i,
    input exec_pkg::exec_rsp_t rsp_o
);

    // reset is synchronous, so the edge after a reset cycle shows an empty output
    property empty_output_in_reset;
        @(posedge clk_i) reset_i |=> !rsp_valid_o;
    endproperty

    // a response that is not taken stays put with the same payload
    property stalled_response_stable;
        @(posedge clk_i) disable iff (reset_i)
            (rsp_valid_o && !rsp_ready_i) |=> (rsp_valid_o && $stable(rsp_o));
    endproperty

    // both buffer entries are empty after reset so the producer may send at once
    property ready_after_reset;
        @(posedge clk_i) $fell(reset_i) |-> req_ready_o;
    endproperty

    assert property (empty_output_in_reset)
        else $error("rsp_valid_o was set while reset was held");

    assert property (stalled_response_stable)
        else $error("stalled response changed before it was accepted");

    assert property (ready_after_reset)
        else $error("req_ready_o was low in the first cycle after reset");

endmodule

bind exec_unit exec_unit_assertions u_exec_unit_assertions (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .req_ready_o (req_ready_o),
    .rsp_valid_o (rsp_valid_o),
    .rsp_ready_i (rsp_ready_i),
    .rsp_o       (rsp_o)
);

/* source/exec_unit.sv */
`timescale 1ns/100ps

module exec_unit (
    input  logic                    clk_i,
    input  logic                    reset_i,

    input  logic                    req_valid_i,
    input  exec_pkg::exec_req_t     req_i,
    output logic                    req_ready_o,

    output logic                    rsp_valid_o,
    output exec_pkg::exec_rsp_t     rsp_o,
    input  logic                    rsp_ready_i,

    output exec_pkg::status_flags_t flags_o
);
    import exec_pkg::*;

    logic            stage_valid;
    logic            stage_ready;
    exec_req_t       stage_req;
    logic [WORD-1:0] alu_result;
    status_flags_t   alu_flags;

    exec_input_buffer u_exec_input_buffer (
        .clk_i         (clk_i),
        .reset_i       (reset_i),
        .req_valid_i   (req_valid_i),
        .req_i         (req_i),
        .req_ready_o   (req_ready_o),
        .stage_valid_o (stage_valid),
        .stage_req_o   (stage_req),
        .stage_ready_i (stage_ready)
    );

    // the ALU sees the committed flags so C and V pass through correctly
    alu u_alu (
        .req_i    (stage_req),
        .flags_i  (flags_o),
        .result_o (alu_result),
        .flags_o  (alu_flags)
    );

    exec_output_stage u_exec_output_stage (
        .clk_i         (clk_i),
        .reset_i       (reset_i),
        .stage_valid_i (stage_valid),
        .set_flags_i   (stage_req.set_flags),
        .result_i      (alu_result),
        .next_flags_i  (alu_flags),
        .stage_ready_o (stage_ready),
        .rsp_valid_o   (rsp_valid_o),
        .rsp_o         (rsp_o),
        .rsp_ready_i   (rsp_ready_i),
        .flags_o       (flags_o)
    );

endmodule

/* source/exec_output_stage.sv */
`timescale 1ns/100ps

module exec_output_stage (
    input  logic                      clk_i,
    input  logic                      reset_i,

    input  logic                      stage_valid_i,
    input  logic                      set_flags_i,
    input  logic [exec_pkg::WORD-1:0] result_i,
    input  exec_pkg::status_flags_t   next_flags_i,
    output logic                      stage_ready_o,

    output logic                      rsp_valid_o,
    output exec_pkg::exec_rsp_t       rsp_o,
    input  logic                      rsp_ready_i,

    output exec_pkg::status_flags_t   flags_o
);
    import exec_pkg::*;

    logic          load;
    status_flags_t flags_after;

    // the register can take a new entry when empty or when it drains this edge
    assign stage_ready_o = !rsp_valid_o || rsp_ready_i;
    assign load          = stage_valid_i && stage_ready_o;

    // flags that are architecturally valid once this operation retires
    assign flags_after = set_flags_i ? next_flags_i : flags_o;

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            rsp_valid_o <= 1'b0;
            flags_o     <= '0;
        end else begin
            if (load) begin
                rsp_valid_o <= 1'b1;
            end else if (rsp_ready_i) begin
                rsp_valid_o <= 1'b0;
            end

            if (load && set_flags_i) begin
                flags_o <= next_flags_i;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (load) begin
            rsp_o.result <= result_i;
            rsp_o.flags  <= flags_after;
        end
    end

endmodule

/* source/alu.sv */
`timescale 1ns/100ps

module alu (
    input  exec_pkg::exec_req_t       req_i,
    input  exec_pkg::status_flags_t   flags_i,
    output logic [exec_pkg::WORD-1:0] result_o,
    output exec_pkg::status_flags_t   flags_o
);
    import exec_pkg::*;

    logic [WORD-1:0]          op_a;
    logic [WORD-1:0]          op_b;
    logic [BYTE-1:0]          shift_amt;
    logic                     big_shift;
    logic [$clog2(WORD)-1:0]  rot_amt;
    logic [2*WORD-1:0]        rot_double;
    // one extra bit so the carry out of bit 31 is kept
    logic [WORD:0]            add_sum;
    logic [WORD:0]            sub_diff;
    logic                     add_overflow;
    logic                     sub_overflow;

    assign op_a = req_i.operand_a;
    assign op_b = req_i.operand_b;

    // shifts only look at the bottom byte of operand b
    assign shift_amt = op_b[BYTE-1:0];
    assign big_shift = (shift_amt >= BYTE'(WORD));

    // rotating the doubled word leaves the wrapped bits in the low half
    assign rot_amt    = op_b[$clog2(WORD)-1:0];
    assign rot_double = {op_a, op_a} >> rot_amt;

    assign add_sum  = {1'b0, op_a} + {1'b0, op_b};
    assign sub_diff = {1'b0, op_a} - {1'b0, op_b};

    // add overflows when both inputs share a sign that the sum does not have
    assign add_overflow = ~(op_a[WORD-1] ^ op_b[WORD-1])
                        & (add_sum[WORD-1] ^ op_a[WORD-1]);

    // subtract overflows when the input signs differ and the sign of a is lost
    assign sub_overflow = (op_a[WORD-1] ^ op_b[WORD-1])
                        & (sub_diff[WORD-1] ^ op_a[WORD-1]);

    always_comb begin
        result_o = '0;
        case (req_i.op)
            ALU_LEFT_SHIFT_L: begin
                result_o = big_shift ? '0 : op_a << shift_amt[$clog2(WORD)-1:0];
            end
            ALU_RIGHT_SHIFT_L: begin
                result_o = big_shift ? '0 : op_a >> shift_amt[$clog2(WORD)-1:0];
            end
            ALU_RIGHT_SHIFT_A: begin
                if (big_shift) begin
                    result_o = {WORD{op_a[WORD-1]}};
                end else begin
                    result_o = $signed(op_a) >>> shift_amt[$clog2(WORD)-1:0];
                end
            end
            ALU_ADD:              result_o = add_sum[WORD-1:0];
            ALU_SUB:              result_o = sub_diff[WORD-1:0];
            ALU_AND:              result_o = op_a & op_b;
            ALU_OR:               result_o = op_a | op_b;
            ALU_XOR:              result_o = op_a ^ op_b;
            ALU_ROTATE_R:         result_o = rot_double[WORD-1:0];
            // only the low word of the product is architecturally visible
            ALU_MULT:             result_o = op_a * op_b;
            ALU_NOT:              result_o = ~op_a;
            ALU_BIT_CLEAR:        result_o = op_a & ~op_b;
            ALU_S_EXTEND_HW: begin
                result_o = {{(WORD-HALF_WORD){op_a[HALF_WORD-1]}}, op_a[HALF_WORD-1:0]};
            end
            ALU_S_EXTEND_BYTE: begin
                result_o = {{(WORD-BYTE){op_a[BYTE-1]}}, op_a[BYTE-1:0]};
            end
            ALU_UN_S_EXTEND_HW: begin
                result_o = {{(WORD-HALF_WORD){1'b0}}, op_a[HALF_WORD-1:0]};
            end
            ALU_UN_S_EXTEND_BYTE: begin
                result_o = {{(WORD-BYTE){1'b0}}, op_a[BYTE-1:0]};
            end
            ALU_BYTE_REV_W: begin
                result_o = {op_a[BYTE-1 -: BYTE], op_a[2*BYTE-1 -: BYTE],
                            op_a[3*BYTE-1 -: BYTE], op_a[4*BYTE-1 -: BYTE]};
            end
            ALU_BYTE_REV_P_HW: begin
                // swap the bytes inside each halfword
                result_o = {op_a[3*BYTE-1 -: BYTE], op_a[4*BYTE-1 -: BYTE],
                            op_a[BYTE-1 -: BYTE], op_a[2*BYTE-1 -: BYTE]};
            end
            ALU_BYTE_REV_S_HW: begin
                // low halfword swapped, then sign extended from the new top byte
                result_o = {{(WORD-HALF_WORD){op_a[BYTE-1]}},
                            op_a[BYTE-1 -: BYTE], op_a[2*BYTE-1 -: BYTE]};
            end
            default: result_o = '0;
        endcase
    end

    always_comb begin
        flags_o.negative = result_o[WORD-1];
        flags_o.zero     = (result_o == '0);
        // C and V carry over unless the op is an add or a subtract
        flags_o.carry    = flags_i.carry;
        flags_o.overflow = flags_i.overflow;
        if (req_i.op == ALU_ADD) begin
            flags_o.carry    = add_sum[WORD];
            flags_o.overflow = add_overflow;
        end else if (req_i.op == ALU_SUB) begin
            // carry after subtract means no borrow was taken
            flags_o.carry    = ~sub_diff[WORD];
            flags_o.overflow = sub_overflow;
        end
    end

endmodule

/* source/exec_input_buffer.sv */
`timescale 1ns/100ps

module exec_input_buffer (
    input  logic                clk_i,
    input  logic                reset_i,

    input  logic                req_valid_i,
    input  exec_pkg::exec_req_t req_i,
    output logic                req_ready_o,

    output logic                stage_valid_o,
    output exec_pkg::exec_req_t stage_req_o,
    input  logic                stage_ready_i
);
    import exec_pkg::*;

    logic      main_valid;
    logic      skid_valid;
    exec_req_t main_req;
    exec_req_t skid_req;
    logic      accept;
    logic      leave;

    // ready only depends on the skid flop, so there is no combinational
    // path from the output stage back to the producer
    assign req_ready_o = !skid_valid;

    assign accept = req_valid_i && req_ready_o;
    assign leave  = main_valid && stage_ready_i;

    assign stage_valid_o = main_valid;
    assign stage_req_o   = main_req;

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            main_valid <= 1'b0;
            skid_valid <= 1'b0;
        end else begin
            if (!main_valid || leave) begin
                // main slot is free this edge, the skid entry has priority
                main_valid <= skid_valid || accept;
                skid_valid <= 1'b0;
            end else if (accept) begin
                // main is stalled, park the new request in the skid slot
                skid_valid <= 1'b1;
            end
        end
    end

    // payload registers follow the same steering as the valid bits
    always_ff @(posedge clk_i) begin
        if (!main_valid || leave) begin
            if (skid_valid) begin
                main_req <= skid_req;
            end else if (accept) begin
                main_req <= req_i;
            end
        end else if (accept) begin
            skid_req <= req_i;
        end
    end

endmodule

/* source/exec_pkg.sv */
package exec_pkg;

    // data path widths of the Thumb-style core
    localparam int WORD      = 32;
    localparam int HALF_WORD = 16;
    localparam int BYTE      = 8;

    // operation codes seen by the ALU, in the order the decoder numbers them
    typedef enum logic [4:0] {
        ALU_LEFT_SHIFT_L     = 5'd0,
        ALU_RIGHT_SHIFT_L    = 5'd1,
        ALU_RIGHT_SHIFT_A    = 5'd2,
        ALU_ADD              = 5'd3,
        ALU_SUB              = 5'd4,
        ALU_AND              = 5'd5,
        ALU_OR               = 5'd6,
        ALU_XOR              = 5'd7,
        ALU_ROTATE_R         = 5'd8,
        ALU_MULT             = 5'd9,
        ALU_NOT              = 5'd10,
        ALU_BIT_CLEAR        = 5'd11,
        ALU_S_EXTEND_HW      = 5'd12,
        ALU_S_EXTEND_BYTE    = 5'd13,
        ALU_UN_S_EXTEND_HW   = 5'd14,
        ALU_UN_S_EXTEND_BYTE = 5'd15,
        ALU_BYTE_REV_W       = 5'd16,
        ALU_BYTE_REV_P_HW    = 5'd17,
        ALU_BYTE_REV_S_HW    = 5'd18
    } alu_op_e;

    // architectural condition flags, N in the top bit
    typedef struct packed {
        logic negative;
        logic zero;
        logic carry;
        logic overflow;
    } status_flags_t;

    // one request for the execute unit
    typedef struct packed {
        alu_op_e         op;
        logic            set_flags;
        logic [WORD-1:0] operand_a;
        logic [WORD-1:0] operand_b;
    } exec_req_t;

    // result of one request with the flags valid after it
    typedef struct packed {
        logic [WORD-1:0] result;
        status_flags_t   flags;
    } exec_rsp_t;

endpackage
